/* sources.f */
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_muldiv.sv
hdl/exec_csr_file.sv
hdl/exec_stage.sv
hdl/exec_top.sv
verif/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= exec_tb
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verif/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

	localparam int wait_limit = 300;
	localparam int random_count = 400;

	logic i_clock;
	logic i_reset;
	logic i_hold;
	logic i_strobe;
	exec_op_t i_op;
	logic [xlen-1:0] i_pc;
	logic [xlen-1:0] i_imm;
	logic [xlen-1:0] i_rs1;
	logic [xlen-1:0] i_rs2;
	logic [reg_index_width-1:0] i_rd;
	logic o_strobe;
	logic o_busy;
	logic [reg_index_width-1:0] o_rd_index;
	logic [xlen-1:0] o_rd_value;
	logic o_jump;
	logic [xlen-1:0] o_jump_pc;
	logic o_ecall;
	logic o_fault;

	logic [31:0] lfsr_state;
	logic [xlen-1:0] shadow_csr [4];
	logic fault_model;
	logic expected_strobe;
	logic [reg_index_width-1:0] last_index;

	exec_top exec_top_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_hold(i_hold),
		.i_strobe(i_strobe),
		.i_op(i_op),
		.i_pc(i_pc),
		.i_imm(i_imm),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_rd(i_rd),
		.o_strobe(o_strobe),
		.o_busy(o_busy),
		.o_rd_index(o_rd_index),
		.o_rd_value(o_rd_value),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_ecall(o_ecall),
		.o_fault(o_fault)
	);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	// ========================================
	// Random source and checks

	// Taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	task automatic stop_run(input string reason);
		$display("RESULT: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_word(input string name, input logic [xlen-1:0] expected,
			input logic [xlen-1:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			stop_run("word mismatch");
		end
	endtask

	task automatic check_index(input string name, input logic [reg_index_width-1:0] expected,
			input logic [reg_index_width-1:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %0d actual %0d", name, expected, actual);
			stop_run("rd index mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail %s expected %b actual %b", name, expected, actual);
			stop_run("flag mismatch");
		end
	endtask

	// ========================================
	// Reference model

	function automatic int csr_slot(input logic [11:0] addr);
		case (addr)
			csr_mscratch: return 0;
			csr_mtvec: return 1;
			csr_mepc: return 2;
			csr_mcause: return 3;
			default: return -1;
		endcase
	endfunction

	task automatic model_result(input exec_op_t op, input logic [xlen-1:0] pc, imm, rs1, rs2,
			input logic [reg_index_width-1:0] rd, output logic writes,
			output logic [reg_index_width-1:0] index, output logic [xlen-1:0] value,
			output logic jump, output logic [xlen-1:0] target, output logic ecall);
		logic [2*xlen-1:0] wide;
		logic [xlen-1:0] old;
		logic signed [xlen-1:0] quot;
		logic signed [xlen-1:0] rem_value;
		logic taken;
		logic overflow;
		int slot;
		writes = 1'b1;
		index = rd;
		value = '0;
		jump = 1'b0;
		target = '0;
		ecall = 1'b0;
		taken = 1'b0;
		overflow = (rs1 == 32'h8000_0000) && (rs2 == 32'hffff_ffff);
		case (op)
			op_add: value = rs1 + rs2;
			op_sub: value = rs1 - rs2;
			op_and: value = rs1 & rs2;
			op_or: value = rs1 | rs2;
			op_xor: value = rs1 ^ rs2;
			op_sll: value = rs1 << rs2[4:0];
			op_srl: value = rs1 >> rs2[4:0];
			op_sra: begin
				wide = {{xlen{rs1[xlen-1]}}, rs1} >> rs2[4:0];
				value = wide[xlen-1:0];
			end
			// Flipping the sign bits turns a signed compare into an unsigned one
			op_slt: value = ((rs1 ^ 32'h8000_0000) < (rs2 ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
			op_sltu: value = (rs1 < rs2) ? 32'd1 : 32'd0;
			op_jal: begin
				value = pc + 32'd4;
				jump = 1'b1;
				target = pc + imm;
			end
			op_jalr: begin
				value = pc + 32'd4;
				jump = 1'b1;
				target = (rs1 + imm) & ~32'd1;
			end
			op_beq, op_bne, op_blt, op_bltu: begin
				case (op)
					op_beq: taken = rs1 == rs2;
					op_bne: taken = rs1 != rs2;
					op_blt: taken = (rs1 ^ 32'h8000_0000) < (rs2 ^ 32'h8000_0000);
					default: taken = rs1 < rs2;
				endcase
				writes = 1'b0;
				index = '0;
				jump = 1'b1;
				target = taken ? pc + imm : pc + 32'd4;
			end
			op_csrrw, op_csrrs, op_csrrc: begin
				slot = csr_slot(imm[11:0]);
				old = (slot >= 0) ? shadow_csr[slot] : '0;
				value = old;
				if (slot >= 0) begin
					if (op == op_csrrw)
						shadow_csr[slot] = rs1;
					else if (op == op_csrrs)
						shadow_csr[slot] = old | rs1;
					else
						shadow_csr[slot] = old & ~rs1;
				end
			end
			op_mul, op_mulhu: begin
				wide = {{xlen{1'b0}}, rs1} * {{xlen{1'b0}}, rs2};
				value = (op == op_mul) ? wide[xlen-1:0] : wide[2*xlen-1:xlen];
			end
			op_div, op_rem: begin
				if (rs2 == '0) begin
					value = (op == op_div) ? '1 : rs1;
				end else if (overflow) begin
					value = (op == op_div) ? rs1 : '0;
				end else begin
					// Signed quotient and remainder, truncated toward zero
					quot = $signed(rs1) / $signed(rs2);
					rem_value = $signed(rs1) % $signed(rs2);
					value = (op == op_div) ? quot : rem_value;
				end
			end
			op_divu: value = (rs2 == '0) ? '1 : rs1 / rs2;
			op_remu: value = (rs2 == '0) ? rs1 : rs1 % rs2;
			op_ecall: begin
				writes = 1'b0;
				index = '0;
				ecall = 1'b1;
				shadow_csr[2] = pc;
				shadow_csr[3] = 32'd11;
			end
			default: begin
				writes = 1'b0;
				index = '0;
				fault_model = 1'b1;
			end
		endcase
	endtask

	// ========================================
	// Instruction driver

	// Called on a falling edge; returns on the falling edge after completion
	task automatic run_instr(input string name, input exec_op_t op,
			input logic [xlen-1:0] pc, imm, rs1, rs2, input logic [reg_index_width-1:0] rd);
		logic writes;
		logic [reg_index_width-1:0] exp_index;
		logic [xlen-1:0] exp_value;
		logic exp_jump;
		logic [xlen-1:0] exp_target;
		logic exp_ecall;
		logic held;
		logic done;
		int cycles;
		model_result(op, pc, imm, rs1, rs2, rd, writes, exp_index, exp_value,
			exp_jump, exp_target, exp_ecall);
		check_flag({name, " strobe before issue"}, expected_strobe, o_strobe);
		i_op = op;
		i_pc = pc;
		i_imm = imm;
		i_rs1 = rs1;
		i_rs2 = rs2;
		i_rd = rd;
		i_strobe = ~i_strobe;
		i_hold = take_bits(2) == 0;
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < wait_limit) begin
			held = i_hold;
			@(negedge i_clock);
			cycles++;
			if (o_strobe !== expected_strobe) begin
				done = 1'b1;
				check_flag({name, " no completion under hold"}, 1'b0, held);
			end else begin
				check_flag({name, " busy while pending"}, 1'b1, o_busy);
				check_index({name, " rd index held"}, last_index, o_rd_index);
				check_flag({name, " no jump while pending"}, 1'b0, o_jump);
				check_flag({name, " no ecall while pending"}, 1'b0, o_ecall);
				i_hold = take_bits(2) == 0;
			end
		end
		if (!done) begin
			$display("Timeout waiting for o_strobe to toggle on %s", name);
			stop_run("o_strobe wait expired");
		end
		expected_strobe = ~expected_strobe;
		last_index = exp_index;
		check_index({name, " rd index"}, exp_index, o_rd_index);
		if (writes)
			check_word({name, " rd value"}, exp_value, o_rd_value);
		check_flag({name, " jump"}, exp_jump, o_jump);
		if (exp_jump)
			check_word({name, " jump pc"}, exp_target, o_jump_pc);
		check_flag({name, " ecall"}, exp_ecall, o_ecall);
		check_flag({name, " fault"}, fault_model, o_fault);
		check_flag({name, " busy after completion"}, 1'b0, o_busy);
	endtask

	task automatic random_instr(input int num);
		logic [4:0] code;
		exec_op_t op;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] imm;
		logic [xlen-1:0] rs1;
		logic [xlen-1:0] rs2;
		logic [reg_index_width-1:0] rd;
		logic [2:0] pick;
		code = 5'(take_bits(5) % 26);
		op = exec_op_t'(code);
		pc = take_bits(32) & ~32'd3;
		imm = take_bits(32);
		rs1 = take_bits(32);
		rs2 = take_bits(32);
		rd = reg_index_width'(take_bits(reg_index_width));
		if (op inside {op_csrrw, op_csrrs, op_csrrc}) begin
			pick = 3'(take_bits(3));
			case (pick)
				3'd0, 3'd1: imm = {20'd0, csr_mscratch};
				3'd2: imm = {20'd0, csr_mtvec};
				3'd3: imm = {20'd0, csr_mepc};
				3'd4: imm = {20'd0, csr_mcause};
				default: imm = 32'h0000_07c0;
			endcase
		end
		// Equal operands and zero divisors are rare with full-width values
		if (op inside {op_beq, op_bne, op_blt, op_bltu} && take_bits(2) == 0)
			rs2 = rs1;
		if (op inside {op_div, op_divu, op_rem, op_remu} && take_bits(3) == 0)
			rs2 = '0;
		run_instr($sformatf("random %0d %s", num, op.name()), op, pc, imm, rs1, rs2, rd);
	endtask

	// ========================================
	// Main sequence

	initial begin
		lfsr_state = 32'h3c15;
		fault_model = 1'b0;
		expected_strobe = 1'b0;
		last_index = '0;
		for (int i = 0; i < 4; i++)
			shadow_csr[i] = '0;
		i_reset = 1'b1;
		i_hold = 1'b0;
		i_strobe = 1'b0;
		i_op = op_add;
		i_pc = '0;
		i_imm = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_rd = '0;
		repeat (5) @(negedge i_clock);
		i_reset = 1'b0;
		@(negedge i_clock);
		check_flag("reset strobe", 1'b0, o_strobe);
		check_flag("reset fault", 1'b0, o_fault);
		check_flag("reset jump", 1'b0, o_jump);
		check_flag("reset ecall", 1'b0, o_ecall);

		// CSR access sequences
		run_instr("csrrw mscratch", op_csrrw, 32'h100, {20'd0, csr_mscratch}, 32'h1234_5678, 0, 5'd3);
		run_instr("csrrs mscratch", op_csrrs, 32'h104, {20'd0, csr_mscratch}, 32'h0f00_00f0, 0, 5'd4);
		run_instr("csrrc mscratch", op_csrrc, 32'h108, {20'd0, csr_mscratch}, 32'h1000_0008, 0, 5'd5);
		run_instr("csrrs mscratch read", op_csrrs, 32'h10c, {20'd0, csr_mscratch}, 0, 0, 5'd6);
		run_instr("csrrw mtvec", op_csrrw, 32'h110, {20'd0, csr_mtvec}, 32'h8000_0100, 0, 5'd7);
		run_instr("csrrw unknown", op_csrrw, 32'h114, 32'h0000_07c0, 32'hdead_beef, 0, 5'd8);
		run_instr("csrrs unknown read", op_csrrs, 32'h118, 32'h0000_07c0, 0, 0, 5'd9);

		// Ecall then read back mepc and mcause
		run_instr("ecall", op_ecall, 32'h1000_0040, 0, 0, 0, 5'd1);
		run_instr("read mepc", op_csrrs, 32'h1000_0044, {20'd0, csr_mepc}, 0, 0, 5'd10);
		run_instr("read mcause", op_csrrs, 32'h1000_0048, {20'd0, csr_mcause}, 0, 0, 5'd11);

		// Divide corner cases
		run_instr("div by zero", op_div, 32'h200, 0, 32'h0000_1234, 0, 5'd12);
		run_instr("divu by zero", op_divu, 32'h204, 0, 32'h8000_0001, 0, 5'd13);
		run_instr("rem by zero", op_rem, 32'h208, 0, 32'hffff_fff0, 0, 5'd14);
		run_instr("remu by zero", op_remu, 32'h20c, 0, 32'h0000_0077, 0, 5'd15);
		run_instr("div overflow", op_div, 32'h210, 0, 32'h8000_0000, 32'hffff_ffff, 5'd16);
		run_instr("rem overflow", op_rem, 32'h214, 0, 32'h8000_0000, 32'hffff_ffff, 5'd17);
		run_instr("div negative", op_div, 32'h218, 0, 32'hffff_ff9c, 32'd7, 5'd18);
		run_instr("rem negative", op_rem, 32'h21c, 0, 32'hffff_ff9c, 32'd7, 5'd19);

		for (int n = 0; n < random_count; n++)
			random_instr(n);

		// Invalid opcode sets a sticky fault
		run_instr("invalid op", exec_op_t'(5'd29), 32'h300, 0, 32'h55, 32'haa, 5'd20);
		run_instr("after fault", op_add, 32'h304, 0, 32'd2, 32'd3, 5'd21);

		// Idle cycles must not produce another completion
		repeat (10) begin
			@(negedge i_clock);
			check_flag("idle strobe", expected_strobe, o_strobe);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* hdl/exec_top.sv */
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_hold,
	input logic i_strobe,
	input exec_op_t i_op,
	input logic [xlen-1:0] i_pc,
	input logic [xlen-1:0] i_imm,
	input logic [xlen-1:0] i_rs1,
	input logic [xlen-1:0] i_rs2,
	input logic [reg_index_width-1:0] i_rd,
	output logic o_strobe,
	output logic o_busy,
	output logic [reg_index_width-1:0] o_rd_index,
	output logic [xlen-1:0] o_rd_value,
	output logic o_jump,
	output logic [xlen-1:0] o_jump_pc,
	output logic o_ecall,
	output logic o_fault
);

	logic [11:0] csr_index;
	csr_access_t csr_access;
	logic [xlen-1:0] csr_wvalue;
	logic [xlen-1:0] csr_rdata;
	logic epc_write;
	logic [xlen-1:0] epc_value;

	logic md_req;
	muldiv_op_t md_op;
	logic [xlen-1:0] md_a;
	logic [xlen-1:0] md_b;
	logic md_ack;
	logic [xlen-1:0] md_result;

	exec_stage exec_stage_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_hold(i_hold),
		.i_strobe(i_strobe),
		.i_op(i_op),
		.i_pc(i_pc),
		.i_imm(i_imm),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_rd(i_rd),
		.o_strobe(o_strobe),
		.o_busy(o_busy),
		.o_rd_index(o_rd_index),
		.o_rd_value(o_rd_value),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_ecall(o_ecall),
		.o_fault(o_fault),
		.o_csr_index(csr_index),
		.o_csr_access(csr_access),
		.o_csr_wvalue(csr_wvalue),
		.i_csr_rdata(csr_rdata),
		.o_epc_write(epc_write),
		.o_epc_value(epc_value),
		.o_md_req(md_req),
		.o_md_op(md_op),
		.o_md_a(md_a),
		.o_md_b(md_b),
		.i_md_ack(md_ack),
		.i_md_result(md_result)
	);

	exec_csr_file exec_csr_file_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_index(csr_index),
		.i_access(csr_access),
		.i_wvalue(csr_wvalue),
		.i_epc_write(epc_write),
		.i_epc_value(epc_value),
		.o_rdata(csr_rdata)
	);

	exec_muldiv exec_muldiv_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(md_req),
		.i_op(md_op),
		.i_a(md_a),
		.i_b(md_b),
		.o_ack(md_ack),
		.o_result(md_result)
	);

endmodule

/* hdl/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_hold,

	// Decode side
	input logic i_strobe,
	input exec_op_t i_op,
	input logic [xlen-1:0] i_pc,
	input logic [xlen-1:0] i_imm,
	input logic [xlen-1:0] i_rs1,
	input logic [xlen-1:0] i_rs2,
	input logic [reg_index_width-1:0] i_rd,

	// Consumer side
	output logic o_strobe,
	output logic o_busy,
	output logic [reg_index_width-1:0] o_rd_index,
	output logic [xlen-1:0] o_rd_value,
	output logic o_jump,
	output logic [xlen-1:0] o_jump_pc,
	output logic o_ecall,
	output logic o_fault,

	// CSR block
	output logic [11:0] o_csr_index,
	output csr_access_t o_csr_access,
	output logic [xlen-1:0] o_csr_wvalue,
	input logic [xlen-1:0] i_csr_rdata,
	output logic o_epc_write,
	output logic [xlen-1:0] o_epc_value,

	// Multiply/divide unit
	output logic o_md_req,
	output muldiv_op_t o_md_op,
	output logic [xlen-1:0] o_md_a,
	output logic [xlen-1:0] o_md_b,
	input logic i_md_ack,
	input logic [xlen-1:0] i_md_result
);

	logic last_strobe;
	logic pending;
	logic accept;
	logic is_md;
	logic complete;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_result;
	logic alu_taken;

	logic [reg_index_width-1:0] res_index;
	logic [xlen-1:0] res_value;
	logic res_jump;
	logic [xlen-1:0] res_target;
	logic res_invalid;

	assign pending = i_strobe != last_strobe;
	assign accept = pending && !i_hold;
	assign is_md = i_op inside {op_mul, op_mulhu, op_div, op_divu, op_rem, op_remu};
	// A multiply or divide finishes only once its ack is in
	assign complete = accept && (!is_md || (o_md_req && i_md_ack));
	assign o_busy = pending;
	assign pc_plus4 = i_pc + 32'd4;
	assign alu_b = (i_op == op_jalr) ? i_imm : i_rs2;

	exec_alu exec_alu_inst (
		.i_op(i_op),
		.i_a(i_rs1),
		.i_b(alu_b),
		.o_result(alu_result),
		.o_taken(alu_taken)
	);

	// ========================================
	// Side channels

	assign o_csr_index = i_imm[11:0];
	assign o_csr_wvalue = i_rs1;
	assign o_epc_write = accept && (i_op == op_ecall);
	assign o_epc_value = i_pc;
	assign o_md_a = i_rs1;
	assign o_md_b = i_rs2;

	always_comb begin
		o_csr_access = csr_none;
		if (accept) begin
			case (i_op)
				op_csrrw: o_csr_access = csr_write;
				op_csrrs: o_csr_access = csr_set;
				op_csrrc: o_csr_access = csr_clear;
				default: o_csr_access = csr_none;
			endcase
		end
	end

	always_comb begin
		case (i_op)
			op_mulhu: o_md_op = md_mulhu;
			op_div: o_md_op = md_div;
			op_divu: o_md_op = md_divu;
			op_rem: o_md_op = md_rem;
			op_remu: o_md_op = md_remu;
			default: o_md_op = md_mul;
		endcase
	end

	// ========================================
	// Result selection

	always_comb begin
		res_index = i_rd;
		res_value = alu_result;
		res_jump = 1'b0;
		res_target = pc_plus4;
		res_invalid = 1'b0;
		case (i_op)
			op_add, op_sub, op_and, op_or, op_xor,
			op_sll, op_srl, op_sra, op_slt, op_sltu: ;
			op_jal: begin
				res_value = pc_plus4;
				res_jump = 1'b1;
				res_target = i_pc + i_imm;
			end
			op_jalr: begin
				res_value = pc_plus4;
				res_jump = 1'b1;
				res_target = {alu_result[xlen-1:1], 1'b0};
			end
			op_beq, op_bne, op_blt, op_bltu: begin
				res_index = '0;
				res_value = '0;
				res_jump = 1'b1;
				res_target = alu_taken ? (i_pc + i_imm) : pc_plus4;
			end
			// Old CSR value goes to rd
			op_csrrw, op_csrrs, op_csrrc: res_value = i_csr_rdata;
			op_mul, op_mulhu, op_div, op_divu, op_rem, op_remu: res_value = i_md_result;
			op_ecall: begin
				res_index = '0;
				res_value = '0;
			end
			default: begin
				res_index = '0;
				res_value = '0;
				res_invalid = 1'b1;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			last_strobe <= 1'b0;
			o_strobe <= 1'b0;
			o_rd_index <= '0;
			o_jump <= 1'b0;
			o_ecall <= 1'b0;
			o_fault <= 1'b0;
			o_md_req <= 1'b0;
		end else begin
			o_jump <= 1'b0;
			o_ecall <= 1'b0;
			// Raise req only once the unit has dropped its previous ack
			if (accept && is_md && !o_md_req && !i_md_ack)
				o_md_req <= 1'b1;
			if (complete) begin
				last_strobe <= i_strobe;
				o_strobe <= ~o_strobe;
				o_rd_index <= res_index;
				o_rd_value <= res_value;
				o_jump <= res_jump;
				o_jump_pc <= res_target;
				o_ecall <= i_op == op_ecall;
				o_md_req <= 1'b0;
				if (res_invalid)
					o_fault <= 1'b1;
			end
		end
	end

endmodule

/* hdl/exec_csr_file.sv */
`timescale 1ns/1ps

module exec_csr_file import exec_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic [11:0] i_index,
	input csr_access_t i_access,
	input logic [xlen-1:0] i_wvalue,
	input logic i_epc_write,
	input logic [xlen-1:0] i_epc_value,
	output logic [xlen-1:0] o_rdata
);

	logic [xlen-1:0] mscratch;
	logic [xlen-1:0] mtvec;
	logic [xlen-1:0] mepc;
	logic [xlen-1:0] mcause;
	logic [xlen-1:0] next_value;

	// Unknown addresses read as zero
	always_comb begin
		case (i_index)
			csr_mscratch: o_rdata = mscratch;
			csr_mtvec: o_rdata = mtvec;
			csr_mepc: o_rdata = mepc;
			csr_mcause: o_rdata = mcause;
			default: o_rdata = '0;
		endcase
	end

	always_comb begin
		case (i_access)
			csr_write: next_value = i_wvalue;
			csr_set: next_value = o_rdata | i_wvalue;
			csr_clear: next_value = o_rdata & ~i_wvalue;
			default: next_value = o_rdata;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mscratch <= '0;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else if (i_epc_write) begin
			mepc <= i_epc_value;
			mcause <= mcause_ecall;
		end else if (i_access != csr_none) begin
			case (i_index)
				csr_mscratch: mscratch <= next_value;
				csr_mtvec: mtvec <= next_value;
				csr_mepc: mepc <= next_value;
				csr_mcause: mcause <= next_value;
				default: ;
			endcase
		end
	end

endmodule

/* hdl/exec_muldiv.sv */
`timescale 1ns/1ps

module exec_muldiv import exec_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_req,
	input muldiv_op_t i_op,
	input logic [xlen-1:0] i_a,
	input logic [xlen-1:0] i_b,
	output logic o_ack,
	output logic [xlen-1:0] o_result
);

	typedef enum logic [1:0] {st_idle, st_run, st_finish, st_done} state_t;

	state_t state;
	logic [$clog2(xlen)-1:0] count;
	muldiv_op_t op_q;
	logic negate;
	logic [xlen:0] acc_hi;
	logic [xlen-1:0] acc_lo;
	logic [xlen-1:0] operand;

	logic is_mul;
	logic is_signed;
	logic a_neg;
	logic b_neg;
	logic div_zero;
	logic overflow;
	logic run_mul;
	logic [xlen:0] mul_sum;
	logic [xlen:0] div_shift;
	logic [xlen:0] div_diff;

	assign is_mul = (i_op == md_mul) || (i_op == md_mulhu);
	assign is_signed = (i_op == md_div) || (i_op == md_rem);
	assign a_neg = is_signed && i_a[xlen-1];
	assign b_neg = is_signed && i_b[xlen-1];
	assign div_zero = i_b == '0;
	assign overflow = is_signed && (i_a == {1'b1, {(xlen-1){1'b0}}}) && (i_b == '1);
	assign run_mul = (op_q == md_mul) || (op_q == md_mulhu);

	// One step of shift-add or restoring shift-subtract
	always_comb begin
		mul_sum = {1'b0, acc_hi[xlen-1:0]} + (acc_lo[0] ? {1'b0, operand} : '0);
		div_shift = {acc_hi[xlen-1:0], acc_lo[xlen-1]};
		div_diff = div_shift - {1'b0, operand};
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= st_idle;
			o_ack <= 1'b0;
			count <= '0;
		end else begin
			case (state)
				st_idle: if (i_req) begin
					op_q <= i_op;
					count <= '0;
					acc_hi <= '0;
					state <= st_run;
					if (is_mul) begin
						acc_lo <= i_b;
						operand <= i_a;
						negate <= 1'b0;
					end else begin
						// Divide on magnitudes, sign restored at the end
						acc_lo <= a_neg ? -i_a : i_a;
						operand <= b_neg ? -i_b : i_b;
						negate <= (i_op == md_div) ? (a_neg ^ b_neg) : a_neg;
						if (div_zero || overflow) begin
							state <= st_done;
							o_ack <= 1'b1;
							if (i_op == md_rem || i_op == md_remu)
								o_result <= div_zero ? i_a : '0;
							else
								o_result <= div_zero ? '1 : i_a;
						end
					end
				end
				st_run: begin
					if (run_mul) begin
						{acc_hi, acc_lo} <= {1'b0, mul_sum, acc_lo[xlen-1:1]};
					end else if (!div_diff[xlen]) begin
						acc_hi <= div_diff;
						acc_lo <= {acc_lo[xlen-2:0], 1'b1};
					end else begin
						acc_hi <= div_shift;
						acc_lo <= {acc_lo[xlen-2:0], 1'b0};
					end
					count <= count + 1'b1;
					if (count == '1)
						state <= st_finish;
				end
				st_finish: begin
					case (op_q)
						md_mul: o_result <= acc_lo;
						md_mulhu: o_result <= acc_hi[xlen-1:0];
						md_div, md_divu: o_result <= negate ? -acc_lo : acc_lo;
						default: o_result <= negate ? -acc_hi[xlen-1:0] : acc_hi[xlen-1:0];
					endcase
					o_ack <= 1'b1;
					state <= st_done;
				end
				// Hold the result until the requester lets go
				default: if (!i_req) begin
					o_ack <= 1'b0;
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

/* hdl/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
	input exec_op_t i_op,
	input logic [xlen-1:0] i_a,
	input logic [xlen-1:0] i_b,
	output logic [xlen-1:0] o_result,
	output logic o_taken
);

	logic [4:0] shamt;
	logic less_signed;
	logic less_unsigned;
	logic equal;

	assign shamt = i_b[4:0];
	assign less_signed = $signed(i_a) < $signed(i_b);
	assign less_unsigned = i_a < i_b;
	assign equal = i_a == i_b;

	// ========================================
	// Result path

	always_comb begin
		o_result = '0;
		case (i_op)
			// Jalr target is rs1 + imm, so it shares the adder
			op_add, op_jalr: o_result = i_a + i_b;
			op_sub: o_result = i_a - i_b;
			op_and: o_result = i_a & i_b;
			op_or: o_result = i_a | i_b;
			op_xor: o_result = i_a ^ i_b;
			op_sll: o_result = i_a << shamt;
			op_srl: o_result = i_a >> shamt;
			op_sra: o_result = $unsigned($signed(i_a) >>> shamt);
			op_slt: o_result = {{(xlen-1){1'b0}}, less_signed};
			op_sltu: o_result = {{(xlen-1){1'b0}}, less_unsigned};
			default: o_result = '0;
		endcase
	end

	// ========================================
	// Branch condition

	always_comb begin
		o_taken = 1'b0;
		case (i_op)
			op_beq: o_taken = equal;
			op_bne: o_taken = !equal;
			op_blt: o_taken = less_signed;
			op_bltu: o_taken = less_unsigned;
			default: o_taken = 1'b0;
		endcase
	end

endmodule

/* hdl/exec_pkg.sv */
package exec_pkg;

	// ========================================
	// Widths

	localparam int xlen = 32;
	localparam int reg_index_width = 5;

	// ========================================
	// Machine CSR addresses

	localparam logic [11:0] csr_mscratch = 12'h340;
	localparam logic [11:0] csr_mtvec = 12'h305;
	localparam logic [11:0] csr_mepc = 12'h341;
	localparam logic [11:0] csr_mcause = 12'h342;

	// Cause code written to mcause by ecall
	localparam logic [xlen-1:0] mcause_ecall = 32'd11;

	// ========================================
	// Decoded operations

	// Codes past op_ecall are invalid and raise a fault
	typedef enum logic [4:0] {
		op_add = 5'd0,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_sll,
		op_srl,
		op_sra,
		op_slt,
		op_sltu,
		op_jal,
		op_jalr,
		op_beq,
		op_bne,
		op_blt,
		op_bltu,
		op_csrrw,
		op_csrrs,
		op_csrrc,
		op_mul,
		op_mulhu,
		op_div,
		op_divu,
		op_rem,
		op_remu,
		op_ecall
	} exec_op_t;

	typedef enum logic [1:0] {csr_none, csr_write, csr_set, csr_clear} csr_access_t;

	typedef enum logic [2:0] {md_mul, md_mulhu, md_div, md_divu, md_rem, md_remu} muldiv_op_t;

endpackage
